// File: all.f
control_pkg.sv
ins_decoder.sv
phase_sequencer.sv
control_unit.sv
control_unit_assert.sv
control_unit_tb.sv

// File: control_pkg.sv
`default_nettype none

package control_pkg;

    localparam int XLEN = 32;                       // Instruction word width

    //////////////////////////////////////////////////
    // Major opcodes, ins[6:0]

    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;

    //////////////////////////////////////////////////
    // Funct3, ins[14:12]

    localparam logic [2:0] F3_ADD  = 3'b000;        // Also SUB and JALR
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;        // SRL or SRA by ins[30]
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // Access width of loads and stores
    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_BU = 3'b100;
    localparam logic [2:0] F3_HU = 3'b101;

    //////////////////////////////////////////////////
    // Instruction type, for the immediate generator

    localparam logic [2:0] TYPE_NONE = 3'd0;
    localparam logic [2:0] TYPE_R    = 3'd1;
    localparam logic [2:0] TYPE_I    = 3'd2;
    localparam logic [2:0] TYPE_S    = 3'd3;
    localparam logic [2:0] TYPE_B    = 3'd4;
    localparam logic [2:0] TYPE_U    = 3'd5;
    localparam logic [2:0] TYPE_J    = 3'd6;

    //////////////////////////////////////////////////
    // ALU operations

    localparam logic [3:0] ALU_ADD   = 4'd0;
    localparam logic [3:0] ALU_SUB   = 4'd1;
    localparam logic [3:0] ALU_SLL   = 4'd2;
    localparam logic [3:0] ALU_SLT   = 4'd3;
    localparam logic [3:0] ALU_SLTU  = 4'd4;
    localparam logic [3:0] ALU_XOR   = 4'd5;
    localparam logic [3:0] ALU_SRL   = 4'd6;
    localparam logic [3:0] ALU_SRA   = 4'd7;
    localparam logic [3:0] ALU_OR    = 4'd8;
    localparam logic [3:0] ALU_AND   = 4'd9;
    localparam logic [3:0] ALU_COPY2 = 4'd10;       // Pass operand 2

    // Operand and write-back selects
    localparam logic SRC1_RS1    = 1'b0;
    localparam logic SRC1_PC     = 1'b1;
    localparam logic SRC2_RS2    = 1'b0;
    localparam logic SRC2_IMM    = 1'b1;
    localparam logic WSRC_PC4    = 1'b0;            // Link address
    localparam logic WSRC_RESULT = 1'b1;

    //////////////////////////////////////////////////
    // Phases

    localparam logic [2:0] PH_FETCH      = 3'd0;
    localparam logic [2:0] PH_DECODE     = 3'd1;
    localparam logic [2:0] PH_EXECUTE    = 3'd2;
    localparam logic [2:0] PH_MEMORY     = 3'd3;
    localparam logic [2:0] PH_WRITE_BACK = 3'd4;

endpackage

`default_nettype wire

// File: control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit
    import control_pkg::*;
(
    input  wire             CLK,
    input  wire             RESET,
    input  wire  [XLEN-1:0] ins,                    // Held stable by the datapath
    output logic            stall,
    output logic [2:0]      ins_type,
    output logic            illegal,
    output logic            jump,
    output logic            jump_reg,
    output logic            branch,
    output logic [3:0]      alu_op,
    output logic            alu_src1,
    output logic            alu_src2,
    output logic            mem_read,
    output logic            mem_write,
    output logic            mem_to_reg,
    output logic            write_src,
    output logic            reg_write
);

    // Decoded row, valid every cycle
    logic [2:0] dec_ins_type;
    logic       dec_jump;
    logic       dec_jump_reg;
    logic       dec_branch;
    logic [3:0] dec_alu_op;
    logic       dec_alu_src1;
    logic       dec_alu_src2;
    logic       dec_mem_read;
    logic       dec_mem_write;
    logic       dec_mem_to_reg;
    logic       dec_write_src;
    logic       dec_reg_write;
    logic       dec_illegal;

    ins_decoder ins_decoder_i (
        .ins        (ins),
        .ins_type   (dec_ins_type),
        .jump       (dec_jump),
        .jump_reg   (dec_jump_reg),
        .branch     (dec_branch),
        .alu_op     (dec_alu_op),
        .alu_src1   (dec_alu_src1),
        .alu_src2   (dec_alu_src2),
        .mem_read   (dec_mem_read),
        .mem_write  (dec_mem_write),
        .mem_to_reg (dec_mem_to_reg),
        .write_src  (dec_write_src),
        .reg_write  (dec_reg_write),
        .illegal    (dec_illegal)
    );

    phase_sequencer phase_sequencer_i (
        .CLK            (CLK),
        .RESET          (RESET),
        .row_ins_type   (dec_ins_type),
        .row_jump       (dec_jump),
        .row_jump_reg   (dec_jump_reg),
        .row_branch     (dec_branch),
        .row_alu_op     (dec_alu_op),
        .row_alu_src1   (dec_alu_src1),
        .row_alu_src2   (dec_alu_src2),
        .row_mem_read   (dec_mem_read),
        .row_mem_write  (dec_mem_write),
        .row_mem_to_reg (dec_mem_to_reg),
        .row_write_src  (dec_write_src),
        .row_reg_write  (dec_reg_write),
        .row_illegal    (dec_illegal),
        .stall          (stall),
        .ins_type       (ins_type),
        .illegal        (illegal),
        .jump           (jump),
        .jump_reg       (jump_reg),
        .branch         (branch),
        .alu_op         (alu_op),
        .alu_src1       (alu_src1),
        .alu_src2       (alu_src2),
        .mem_read       (mem_read),
        .mem_write      (mem_write),
        .mem_to_reg     (mem_to_reg),
        .write_src      (write_src),
        .reg_write      (reg_write)
    );

endmodule

`default_nettype wire

// File: control_unit_assert.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit_checks
    import control_pkg::*;
(
    input wire       CLK,
    input wire       RESET,
    input wire [31:0] ins,
    input wire       stall,
    input wire [2:0] ins_type,
    input wire       illegal,
    input wire       jump,
    input wire       jump_reg,
    input wire       branch,
    input wire [3:0] alu_op,
    input wire       alu_src1,
    input wire       alu_src2,
    input wire       mem_read,
    input wire       mem_write,
    input wire       mem_to_reg,
    input wire       write_src,
    input wire       reg_write
);

    logic [2:0] run_len;                            // Stall cycles so far, 0 in DECODE
    logic [6:0] run_op;
    logic       run_illegal;
    logic       late_any;
    logic       ctrl_any;
    int         fails_quiet = 0;
    int         fails_order = 0;
    int         fails_mem = 0;
    int         fails_decode = 0;
    int         fails_write = 0;
    int         fail_count;

    assign late_any = jump | jump_reg | branch | (|alu_op) | alu_src1 | alu_src2 | mem_read
                    | mem_write | mem_to_reg | write_src | reg_write;
    assign ctrl_any = late_any | illegal | (|ins_type);
    assign fail_count = fails_quiet + fails_order + fails_mem + fails_decode + fails_write;

    function automatic logic [2:0] stall_cycles(input logic [6:0] op, input logic bad);
        if (bad)
            return 3'd1;
        case (op)
            OP_BRANCH: return 3'd2;
            OP_STORE:  return 3'd3;
            OP_LOAD:   return 3'd4;
            default:   return 3'd3;
        endcase
    endfunction

    always_ff @(posedge CLK)
    begin
        if (RESET || !stall)
        begin
            run_len     <= 3'd0;
            run_illegal <= 1'b0;
        end
        else
        begin
            run_len <= run_len + 3'd1;
            run_op  <= ins[6:0];
            if (illegal)
                run_illegal <= 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Phase order and gating

    quiet_after_reset: assert property (@(posedge CLK) $past(RESET) |-> !stall && !ctrl_any)
        else begin fails_quiet++; $error("control outputs active right after reset"); end
    quiet_in_fetch: assert property (@(posedge CLK) disable iff (RESET) !stall |-> !ctrl_any)
        else begin fails_quiet++; $error("control outputs active in FETCH"); end
    run_length: assert property (@(posedge CLK) disable iff (RESET)
        $fell(stall) |-> run_len == stall_cycles(run_op, run_illegal))
        else begin fails_order++; $error("instruction took the wrong number of cycles"); end

    mem_exclusive: assert property (@(posedge CLK) disable iff (RESET) !(mem_read && mem_write))
        else begin fails_mem++; $error("memory read and write raised together"); end
    mem_in_memory: assert property (@(posedge CLK) disable iff (RESET)
        (mem_read || mem_write) |-> run_len == 3'd2
            && (mem_read ? ins[6:0] == OP_LOAD : ins[6:0] == OP_STORE))
        else begin fails_mem++; $error("memory access outside MEMORY or for the wrong class"); end

    illegal_in_decode: assert property (@(posedge CLK) disable iff (RESET)
        illegal |-> run_len == 3'd0 && !late_any && ins_type == TYPE_NONE)
        else begin fails_decode++; $error("illegal flag outside DECODE or with other outputs"); end
    illegal_aborts: assert property (@(posedge CLK) disable iff (RESET) illegal |=> !stall)
        else begin fails_decode++; $error("illegal instruction did not return to FETCH"); end

    no_write_back: assert property (@(posedge CLK) disable iff (RESET)
        reg_write |-> ins[6:0] != OP_BRANCH && ins[6:0] != OP_STORE)
        else begin fails_write++; $error("register write for a branch or store"); end

endmodule

bind control_unit control_unit_checks control_unit_checks_i (
    .CLK(CLK), .RESET(RESET), .ins(ins), .stall(stall), .ins_type(ins_type),
    .illegal(illegal), .jump(jump), .jump_reg(jump_reg), .branch(branch),
    .alu_op(alu_op), .alu_src1(alu_src1), .alu_src2(alu_src2),
    .mem_read(mem_read), .mem_write(mem_write), .mem_to_reg(mem_to_reg),
    .write_src(write_src), .reg_write(reg_write)
);

`default_nettype wire

// File: control_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit_tb
    import control_pkg::*;
();

    localparam int N_INS      = 400;
    localparam int MAX_CYCLES = 5;
    localparam int CLK_PERIOD = 8;
    localparam int MAX_FORMS  = 40;

    // Instruction classes
    localparam int CL_ALU     = 0;
    localparam int CL_JAL     = 1;
    localparam int CL_JALR    = 2;
    localparam int CL_BRANCH  = 3;
    localparam int CL_LOAD    = 4;
    localparam int CL_STORE   = 5;
    localparam int CL_ILLEGAL = 6;

    localparam logic [31:0] MASK_U = 32'hFFFF_FF80;     // Immediate and rd
    localparam logic [31:0] MASK_I = 32'hFFFF_8F80;     // Also S and B
    localparam logic [31:0] MASK_R = 32'h01FF_8F80;     // Also shift immediates

    logic        CLK;
    logic        RESET;
    logic [31:0] ins;
    logic        stall;
    logic        illegal;
    logic        jump;
    logic        jump_reg;
    logic        branch;
    logic [2:0]  ins_type;
    logic [3:0]  alu_op;
    logic        alu_src1;
    logic        alu_src2;
    logic        mem_read;
    logic        mem_write;
    logic        mem_to_reg;
    logic        write_src;
    logic        reg_write;
    logic [18:0] observed;

    string       form_name  [MAX_FORMS];
    logic [31:0] form_word  [MAX_FORMS];
    logic [31:0] form_mask  [MAX_FORMS];
    int          form_class [MAX_FORMS];
    logic [2:0]  form_type  [MAX_FORMS];
    logic [3:0]  form_alu   [MAX_FORMS];
    logic        form_src1  [MAX_FORMS];
    logic        form_src2  [MAX_FORMS];
    int          form_hits  [MAX_FORMS];
    int          n_forms;
    int          errors;
    integer      seed;

    control_unit control_unit_i (
        .CLK(CLK), .RESET(RESET), .ins(ins), .stall(stall), .ins_type(ins_type),
        .illegal(illegal), .jump(jump), .jump_reg(jump_reg), .branch(branch),
        .alu_op(alu_op), .alu_src1(alu_src1), .alu_src2(alu_src2),
        .mem_read(mem_read), .mem_write(mem_write), .mem_to_reg(mem_to_reg),
        .write_src(write_src), .reg_write(reg_write)
    );

    assign observed = {stall, ins_type, illegal, jump, jump_reg, branch, alu_op, alu_src1,
                       alu_src2, mem_read, mem_write, mem_to_reg, write_src, reg_write};

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    //////////////////////////////////////////////////
    // Reference table

    function automatic logic [31:0] encode(input logic b30, input logic [2:0] f3,
                                           input logic [6:0] op);
        return {1'b0, b30, 15'd0, f3, 5'd0, op};
    endfunction

    task automatic add_form(input string name, input logic [31:0] word, input logic [31:0] mask,
                            input int cls, input logic [2:0] itype, input logic [3:0] alu,
                            input logic src1, input logic src2);
        form_name[n_forms]  = name;
        form_word[n_forms]  = word;
        form_mask[n_forms]  = mask;
        form_class[n_forms] = cls;
        form_type[n_forms]  = itype;
        form_alu[n_forms]   = alu;
        form_src1[n_forms]  = src1;
        form_src2[n_forms]  = src2;
        form_hits[n_forms]  = 0;
        n_forms++;
    endtask

    task automatic build_forms();
        add_form("LUI", encode(1'b0, 3'd0, OP_LUI), MASK_U,
                 CL_ALU, TYPE_U, ALU_COPY2, SRC1_RS1, SRC2_IMM);
        add_form("AUIPC", encode(1'b0, 3'd0, OP_AUIPC), MASK_U,
                 CL_ALU, TYPE_U, ALU_ADD, SRC1_PC, SRC2_IMM);
        add_form("JAL", encode(1'b0, 3'd0, OP_JAL), MASK_U,
                 CL_JAL, TYPE_J, ALU_ADD, SRC1_RS1, SRC2_RS2);
        add_form("JALR", encode(1'b0, F3_ADD, OP_JALR), MASK_I,
                 CL_JALR, TYPE_I, ALU_ADD, SRC1_RS1, SRC2_RS2);
        add_form("BEQ", encode(1'b0, 3'd0, OP_BRANCH), MASK_I,
                 CL_BRANCH, TYPE_B, ALU_ADD, SRC1_RS1, SRC2_RS2);
        add_form("BNE", encode(1'b0, 3'd1, OP_BRANCH), MASK_I,
                 CL_BRANCH, TYPE_B, ALU_ADD, SRC1_RS1, SRC2_RS2);
        add_form("BLT", encode(1'b0, 3'd4, OP_BRANCH), MASK_I,
                 CL_BRANCH, TYPE_B, ALU_ADD, SRC1_RS1, SRC2_RS2);
        add_form("BGE", encode(1'b0, 3'd5, OP_BRANCH), MASK_I,
                 CL_BRANCH, TYPE_B, ALU_ADD, SRC1_RS1, SRC2_RS2);
        add_form("BLTU", encode(1'b0, 3'd6, OP_BRANCH), MASK_I,
                 CL_BRANCH, TYPE_B, ALU_ADD, SRC1_RS1, SRC2_RS2);
        add_form("BGEU", encode(1'b0, 3'd7, OP_BRANCH), MASK_I,
                 CL_BRANCH, TYPE_B, ALU_ADD, SRC1_RS1, SRC2_RS2);
        add_form("LB", encode(1'b0, F3_B, OP_LOAD), MASK_I,
                 CL_LOAD, TYPE_I, ALU_ADD, SRC1_RS1, SRC2_IMM);
        add_form("LH", encode(1'b0, F3_H, OP_LOAD), MASK_I,
                 CL_LOAD, TYPE_I, ALU_ADD, SRC1_RS1, SRC2_IMM);
        add_form("LW", encode(1'b0, F3_W, OP_LOAD), MASK_I,
                 CL_LOAD, TYPE_I, ALU_ADD, SRC1_RS1, SRC2_IMM);
        add_form("LBU", encode(1'b0, F3_BU, OP_LOAD), MASK_I,
                 CL_LOAD, TYPE_I, ALU_ADD, SRC1_RS1, SRC2_IMM);
        add_form("LHU", encode(1'b0, F3_HU, OP_LOAD), MASK_I,
                 CL_LOAD, TYPE_I, ALU_ADD, SRC1_RS1, SRC2_IMM);
        add_form("SB", encode(1'b0, F3_B, OP_STORE), MASK_I,
                 CL_STORE, TYPE_S, ALU_ADD, SRC1_RS1, SRC2_IMM);
        add_form("SH", encode(1'b0, F3_H, OP_STORE), MASK_I,
                 CL_STORE, TYPE_S, ALU_ADD, SRC1_RS1, SRC2_IMM);
        add_form("SW", encode(1'b0, F3_W, OP_STORE), MASK_I,
                 CL_STORE, TYPE_S, ALU_ADD, SRC1_RS1, SRC2_IMM);
        add_form("ADDI", encode(1'b0, F3_ADD, OP_IMM), MASK_I,
                 CL_ALU, TYPE_I, ALU_ADD, SRC1_RS1, SRC2_IMM);
        add_form("SLTI", encode(1'b0, F3_SLT, OP_IMM), MASK_I,
                 CL_ALU, TYPE_I, ALU_SLT, SRC1_RS1, SRC2_IMM);
        add_form("SLTIU", encode(1'b0, F3_SLTU, OP_IMM), MASK_I,
                 CL_ALU, TYPE_I, ALU_SLTU, SRC1_RS1, SRC2_IMM);
        add_form("XORI", encode(1'b0, F3_XOR, OP_IMM), MASK_I,
                 CL_ALU, TYPE_I, ALU_XOR, SRC1_RS1, SRC2_IMM);
        add_form("ORI", encode(1'b0, F3_OR, OP_IMM), MASK_I,
                 CL_ALU, TYPE_I, ALU_OR, SRC1_RS1, SRC2_IMM);
        add_form("ANDI", encode(1'b0, F3_AND, OP_IMM), MASK_I,
                 CL_ALU, TYPE_I, ALU_AND, SRC1_RS1, SRC2_IMM);
        add_form("SLLI", encode(1'b0, F3_SLL, OP_IMM), MASK_R,
                 CL_ALU, TYPE_I, ALU_SLL, SRC1_RS1, SRC2_IMM);
        add_form("SRLI", encode(1'b0, F3_SR, OP_IMM), MASK_R,
                 CL_ALU, TYPE_I, ALU_SRL, SRC1_RS1, SRC2_IMM);
        add_form("SRAI", encode(1'b1, F3_SR, OP_IMM), MASK_R,
                 CL_ALU, TYPE_I, ALU_SRA, SRC1_RS1, SRC2_IMM);
        add_form("ADD", encode(1'b0, F3_ADD, OP_REG), MASK_R,
                 CL_ALU, TYPE_R, ALU_ADD, SRC1_RS1, SRC2_RS2);
        add_form("SUB", encode(1'b1, F3_ADD, OP_REG), MASK_R,
                 CL_ALU, TYPE_R, ALU_SUB, SRC1_RS1, SRC2_RS2);
        add_form("SLL", encode(1'b0, F3_SLL, OP_REG), MASK_R,
                 CL_ALU, TYPE_R, ALU_SLL, SRC1_RS1, SRC2_RS2);
        add_form("SLT", encode(1'b0, F3_SLT, OP_REG), MASK_R,
                 CL_ALU, TYPE_R, ALU_SLT, SRC1_RS1, SRC2_RS2);
        add_form("SLTU", encode(1'b0, F3_SLTU, OP_REG), MASK_R,
                 CL_ALU, TYPE_R, ALU_SLTU, SRC1_RS1, SRC2_RS2);
        add_form("XOR", encode(1'b0, F3_XOR, OP_REG), MASK_R,
                 CL_ALU, TYPE_R, ALU_XOR, SRC1_RS1, SRC2_RS2);
        add_form("SRL", encode(1'b0, F3_SR, OP_REG), MASK_R,
                 CL_ALU, TYPE_R, ALU_SRL, SRC1_RS1, SRC2_RS2);
        add_form("SRA", encode(1'b1, F3_SR, OP_REG), MASK_R,
                 CL_ALU, TYPE_R, ALU_SRA, SRC1_RS1, SRC2_RS2);
        add_form("OR", encode(1'b0, F3_OR, OP_REG), MASK_R,
                 CL_ALU, TYPE_R, ALU_OR, SRC1_RS1, SRC2_RS2);
        add_form("AND", encode(1'b0, F3_AND, OP_REG), MASK_R,
                 CL_ALU, TYPE_R, ALU_AND, SRC1_RS1, SRC2_RS2);
        // Illegal words
        add_form("BAD_OPCODE", encode(1'b0, 3'd0, 7'h7F), MASK_U,
                 CL_ILLEGAL, TYPE_NONE, ALU_ADD, 1'b0, 1'b0);
        add_form("SLLI_BIT30", encode(1'b1, F3_SLL, OP_IMM), MASK_R,
                 CL_ILLEGAL, TYPE_NONE, ALU_ADD, 1'b0, 1'b0);
        add_form("LOAD_F3_3", encode(1'b0, 3'd3, OP_LOAD), MASK_I,
                 CL_ILLEGAL, TYPE_NONE, ALU_ADD, 1'b0, 1'b0);
    endtask

    function automatic int class_cycles(input int cls);
        case (cls)
            CL_ILLEGAL: return 2;
            CL_BRANCH:  return 3;
            CL_LOAD:    return 5;
            default:    return 4;                   // Stores, jumps and ALU operations
        endcase
    endfunction

    function automatic logic [2:0] expected_phase(input int cls, input int k);
        if (k >= class_cycles(cls))
            return PH_FETCH;
        case (k)
            1:       return PH_DECODE;
            2:       return PH_EXECUTE;
            3:       return (cls == CL_LOAD || cls == CL_STORE) ? PH_MEMORY : PH_WRITE_BACK;
            4:       return PH_WRITE_BACK;
            default: return PH_FETCH;
        endcase
    endfunction

    // Order matches observed
    function automatic logic [18:0] expected_outputs(input int idx, input logic [2:0] ph);
        int   cls;
        logic legal;
        logic ex;
        logic mem;
        logic wb;
        logic link;
        cls   = form_class[idx];
        legal = (cls != CL_ILLEGAL);
        ex    = (ph == PH_EXECUTE);
        mem   = (ph == PH_MEMORY);
        wb    = (ph == PH_WRITE_BACK);
        link  = (cls == CL_JAL || cls == CL_JALR);
        if (ph == PH_FETCH)
            return 19'd0;
        return {1'b1, legal ? form_type[idx] : TYPE_NONE, ph == PH_DECODE && !legal,
                ex && cls == CL_JAL, ex && cls == CL_JALR, ex && cls == CL_BRANCH,
                ex ? form_alu[idx] : 4'd0, ex && form_src1[idx], ex && form_src2[idx],
                mem && cls == CL_LOAD, mem && cls == CL_STORE, wb && cls == CL_LOAD,
                wb ? (link ? WSRC_PC4 : WSRC_RESULT) : 1'b0, wb};
    endfunction

    //////////////////////////////////////////////////
    // Checks and stimulus

    task automatic check_outputs(input string test, input logic [18:0] expected);
        assert (observed === expected)
        else
        begin
            $display("CHECK FAILED %s: expected %b, actual %b", test, expected, observed);
            errors++;
        end
    endtask

    task automatic check_count(input string test, input int expected, input int actual);
        assert (actual == expected)
        else
        begin
            $display("CHECK FAILED %s: expected %0d, actual %0d", test, expected, actual);
            errors++;
        end
    endtask

    // Forces forms not yet seen once the remaining slots run short
    function automatic int pick_form(input int left);
        int unseen;
        int first;
        unseen = 0;
        first  = -1;
        for (int i = 0; i < n_forms; i++)
        begin
            if (form_hits[i] == 0)
            begin
                unseen++;
                if (first < 0)
                    first = i;
            end
        end
        if (unseen > 0 && unseen >= left)
            return first;
        return $unsigned($random(seed)) % n_forms;
    endfunction

    // Steps one instruction up to the next FETCH and checks every cycle
    task automatic run_instruction(input int idx);
        int k;
        k = 0;
        do
        begin
            @(negedge CLK);
            k++;
            check_outputs($sformatf("%s cycle %0d", form_name[idx], k),
                          expected_outputs(idx, expected_phase(form_class[idx], k)));
        end
        while (stall === 1'b1 && k <= MAX_CYCLES);
        check_count($sformatf("%s length", form_name[idx]), class_cycles(form_class[idx]), k);
    endtask

    initial
    begin
        int          idx;
        int          bound_errors;
        logic [31:0] fill;
        CLK     = 1'b0;
        RESET   = 1'b1;
        ins     = '0;
        errors  = 0;
        n_forms = 0;
        seed    = 77394;
        build_forms();
        repeat (2) @(negedge CLK);
        RESET = 1'b0;
        check_outputs("first cycle after reset", 19'd0);
        for (int n = 0; n < N_INS; n++)
        begin
            idx  = pick_form(N_INS - n);
            fill = $random(seed);
            ins  = (form_word[idx] & ~form_mask[idx]) | (fill & form_mask[idx]);
            form_hits[idx]++;
            run_instruction(idx);
        end
        @(posedge CLK);                             // Last FETCH seen by the bound checks
        @(negedge CLK);
        bound_errors = control_unit_i.control_unit_checks_i.fail_count;
        $display("Errors: %0d (testbench checks %0d, bound assertions %0d)",
                 errors + bound_errors, errors, bound_errors);
        if (errors + bound_errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

    // Watchdog
    initial
    begin
        #(N_INS * MAX_CYCLES * CLK_PERIOD + 1000);
        $display("Timeout: the instruction sequence did not finish in time");
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: ins_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module ins_decoder
    import control_pkg::*;
(
    input  wire  [XLEN-1:0] ins,
    output logic [2:0]      ins_type,
    output logic            jump,
    output logic            jump_reg,
    output logic            branch,
    output logic [3:0]      alu_op,
    output logic            alu_src1,
    output logic            alu_src2,
    output logic            mem_read,
    output logic            mem_write,
    output logic            mem_to_reg,
    output logic            write_src,
    output logic            reg_write,
    output logic            illegal
);

    logic [10:0] key;
    logic [16:0] row;

    assign key = {ins[30], ins[14:12], ins[6:0]};   // Bit 30, funct3, opcode

    assign {ins_type, jump, jump_reg, branch, alu_op, alu_src1, alu_src2,
            mem_read, mem_write, mem_to_reg, write_src, reg_write} = row;

    //////////////////////////////////////////////////
    // Decode table
    // type, jump/jalr/branch, ALU op, src1, src2, mem rd/wr/m2r, write source, reg write

    always_comb
    begin
        row     = '0;
        illegal = 1'b0;
        casez (key)
            {1'b?, 3'b???, OP_LUI}:
                row = {TYPE_U, 3'b000, ALU_COPY2, SRC1_RS1, SRC2_IMM, 3'b000, WSRC_RESULT, 1'b1};
            {1'b?, 3'b???, OP_AUIPC}:
                row = {TYPE_U, 3'b000, ALU_ADD, SRC1_PC, SRC2_IMM, 3'b000, WSRC_RESULT, 1'b1};
            {1'b?, 3'b???, OP_JAL}:
                row = {TYPE_J, 3'b100, ALU_ADD, SRC1_RS1, SRC2_RS2, 3'b000, WSRC_PC4, 1'b1};
            {1'b?, F3_ADD, OP_JALR}:
                row = {TYPE_I, 3'b010, ALU_ADD, SRC1_RS1, SRC2_RS2, 3'b000, WSRC_PC4, 1'b1};
            {1'b?, 3'b???, OP_BRANCH}:                      // Compare done by branch unit
                row = {TYPE_B, 3'b001, ALU_ADD, SRC1_RS1, SRC2_RS2, 3'b000, WSRC_RESULT, 1'b0};
            {1'b?, F3_B, OP_LOAD},
            {1'b?, F3_H, OP_LOAD},
            {1'b?, F3_W, OP_LOAD},
            {1'b?, F3_BU, OP_LOAD},
            {1'b?, F3_HU, OP_LOAD}:
                row = {TYPE_I, 3'b000, ALU_ADD, SRC1_RS1, SRC2_IMM, 3'b101, WSRC_RESULT, 1'b1};
            {1'b?, F3_B, OP_STORE},
            {1'b?, F3_H, OP_STORE},
            {1'b?, F3_W, OP_STORE}:
                row = {TYPE_S, 3'b000, ALU_ADD, SRC1_RS1, SRC2_IMM, 3'b010, WSRC_RESULT, 1'b0};

            // Register-immediate
            {1'b?, F3_ADD, OP_IMM}:                         // ADDI
                row = {TYPE_I, 3'b000, ALU_ADD, SRC1_RS1, SRC2_IMM, 3'b000, WSRC_RESULT, 1'b1};
            {1'b?, F3_SLT, OP_IMM}:                         // SLTI
                row = {TYPE_I, 3'b000, ALU_SLT, SRC1_RS1, SRC2_IMM, 3'b000, WSRC_RESULT, 1'b1};
            {1'b?, F3_SLTU, OP_IMM}:                        // SLTIU
                row = {TYPE_I, 3'b000, ALU_SLTU, SRC1_RS1, SRC2_IMM, 3'b000, WSRC_RESULT, 1'b1};
            {1'b?, F3_XOR, OP_IMM}:                         // XORI
                row = {TYPE_I, 3'b000, ALU_XOR, SRC1_RS1, SRC2_IMM, 3'b000, WSRC_RESULT, 1'b1};
            {1'b?, F3_OR, OP_IMM}:                          // ORI
                row = {TYPE_I, 3'b000, ALU_OR, SRC1_RS1, SRC2_IMM, 3'b000, WSRC_RESULT, 1'b1};
            {1'b?, F3_AND, OP_IMM}:                         // ANDI
                row = {TYPE_I, 3'b000, ALU_AND, SRC1_RS1, SRC2_IMM, 3'b000, WSRC_RESULT, 1'b1};
            {1'b0, F3_SLL, OP_IMM}:                         // SLLI
                row = {TYPE_I, 3'b000, ALU_SLL, SRC1_RS1, SRC2_IMM, 3'b000, WSRC_RESULT, 1'b1};
            {1'b0, F3_SR, OP_IMM}:                          // SRLI
                row = {TYPE_I, 3'b000, ALU_SRL, SRC1_RS1, SRC2_IMM, 3'b000, WSRC_RESULT, 1'b1};
            {1'b1, F3_SR, OP_IMM}:                          // SRAI
                row = {TYPE_I, 3'b000, ALU_SRA, SRC1_RS1, SRC2_IMM, 3'b000, WSRC_RESULT, 1'b1};

            // Register-register
            {1'b0, F3_ADD, OP_REG}:                         // ADD
                row = {TYPE_R, 3'b000, ALU_ADD, SRC1_RS1, SRC2_RS2, 3'b000, WSRC_RESULT, 1'b1};
            {1'b1, F3_ADD, OP_REG}:                         // SUB
                row = {TYPE_R, 3'b000, ALU_SUB, SRC1_RS1, SRC2_RS2, 3'b000, WSRC_RESULT, 1'b1};
            {1'b0, F3_SLL, OP_REG}:                         // SLL
                row = {TYPE_R, 3'b000, ALU_SLL, SRC1_RS1, SRC2_RS2, 3'b000, WSRC_RESULT, 1'b1};
            {1'b?, F3_SLT, OP_REG}:                         // SLT
                row = {TYPE_R, 3'b000, ALU_SLT, SRC1_RS1, SRC2_RS2, 3'b000, WSRC_RESULT, 1'b1};
            {1'b?, F3_SLTU, OP_REG}:                        // SLTU
                row = {TYPE_R, 3'b000, ALU_SLTU, SRC1_RS1, SRC2_RS2, 3'b000, WSRC_RESULT, 1'b1};
            {1'b?, F3_XOR, OP_REG}:                         // XOR
                row = {TYPE_R, 3'b000, ALU_XOR, SRC1_RS1, SRC2_RS2, 3'b000, WSRC_RESULT, 1'b1};
            {1'b0, F3_SR, OP_REG}:                          // SRL
                row = {TYPE_R, 3'b000, ALU_SRL, SRC1_RS1, SRC2_RS2, 3'b000, WSRC_RESULT, 1'b1};
            {1'b1, F3_SR, OP_REG}:                          // SRA
                row = {TYPE_R, 3'b000, ALU_SRA, SRC1_RS1, SRC2_RS2, 3'b000, WSRC_RESULT, 1'b1};
            {1'b?, F3_OR, OP_REG}:                          // OR
                row = {TYPE_R, 3'b000, ALU_OR, SRC1_RS1, SRC2_RS2, 3'b000, WSRC_RESULT, 1'b1};
            {1'b?, F3_AND, OP_REG}:                         // AND
                row = {TYPE_R, 3'b000, ALU_AND, SRC1_RS1, SRC2_RS2, 3'b000, WSRC_RESULT, 1'b1};

            default:
                illegal = 1'b1;                             // Row stays all zero
        endcase
    end

endmodule

`default_nettype wire

// File: phase_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module phase_sequencer
    import control_pkg::*;
(
    input  wire        CLK,
    input  wire        RESET,
    input  wire  [2:0] row_ins_type,
    input  wire        row_jump,
    input  wire        row_jump_reg,
    input  wire        row_branch,
    input  wire  [3:0] row_alu_op,
    input  wire        row_alu_src1,
    input  wire        row_alu_src2,
    input  wire        row_mem_read,
    input  wire        row_mem_write,
    input  wire        row_mem_to_reg,
    input  wire        row_write_src,
    input  wire        row_reg_write,
    input  wire        row_illegal,
    output logic       stall,
    output logic [2:0] ins_type,
    output logic       illegal,
    output logic       jump,
    output logic       jump_reg,
    output logic       branch,
    output logic [3:0] alu_op,
    output logic       alu_src1,
    output logic       alu_src2,
    output logic       mem_read,
    output logic       mem_write,
    output logic       mem_to_reg,
    output logic       write_src,
    output logic       reg_write
);

    logic [2:0] phase;
    logic [2:0] phase_next;
    logic       in_decode;
    logic       in_execute;
    logic       in_memory;
    logic       in_write_back;

    //////////////////////////////////////////////////
    // Phase register

    always_comb
    begin
        case (phase)
            PH_FETCH:
                phase_next = PH_DECODE;
            PH_DECODE:
                phase_next = row_illegal ? PH_FETCH : PH_EXECUTE;   // Abort unknown encodings
            PH_EXECUTE:
            begin
                if (row_mem_read || row_mem_write)
                    phase_next = PH_MEMORY;
                else if (row_reg_write)
                    phase_next = PH_WRITE_BACK;
                else
                    phase_next = PH_FETCH;                          // Branches end here
            end
            PH_MEMORY:
                phase_next = row_reg_write ? PH_WRITE_BACK : PH_FETCH;
            default:
                phase_next = PH_FETCH;                              // Write-back and spare codes
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
            phase <= PH_FETCH;
        else
            phase <= phase_next;
    end

    //////////////////////////////////////////////////
    // Output gating, each field only in its own phase

    assign stall         = (phase != PH_FETCH);
    assign in_decode     = (phase == PH_DECODE);
    assign in_execute    = (phase == PH_EXECUTE);
    assign in_memory     = (phase == PH_MEMORY);
    assign in_write_back = (phase == PH_WRITE_BACK);

    assign ins_type   = stall ? row_ins_type : TYPE_NONE;
    assign illegal    = in_decode & row_illegal;

    assign jump       = in_execute & row_jump;
    assign jump_reg   = in_execute & row_jump_reg;
    assign branch     = in_execute & row_branch;
    assign alu_op     = in_execute ? row_alu_op : 4'd0;
    assign alu_src1   = in_execute & row_alu_src1;
    assign alu_src2   = in_execute & row_alu_src2;

    assign mem_read   = in_memory & row_mem_read;
    assign mem_write  = in_memory & row_mem_write;

    assign mem_to_reg = in_write_back & row_mem_to_reg;
    assign write_src  = in_write_back & row_write_src;
    assign reg_write  = in_write_back & row_reg_write;

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the control unit testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert -f all.f --top-module control_unit_tb -o control_unit_sim \
    && ./obj_dir/control_unit_sim +verilator+error+limit+1000 > sim.log 2>&1 \
    || echo "Simulation did not run to the end" >> sim.log
cat sim.log
grep -q "Test failed" sim.log && exit 1 || grep -q "Test completed successfully" sim.log
